//--- logic/dataMemory.sv
`timescale 1ns/100ps

module dataMemory #(
    parameter int memWords = 256,
    parameter int memLatency = 3
) (
    input  logic                           clk,
    input  logic                           reset,
    input  memStagePkg::memReq_t           memReq,
    input  logic                           memReqValid,
    output logic                           memAck,
    output logic [memStagePkg::DATA_W-1:0] memRdata
);
    import memStagePkg::*;

    localparam int IDX_W = (memWords > 1) ? $clog2(memWords) : 1;
    localparam int CNT_W = (memLatency > 1) ? $clog2(memLatency) : 1;

    logic [DATA_W-1:0] mem [memWords];
    logic [IDX_W-1:0] wordIdx;
    logic [CNT_W-1:0] latCount;
    logic busy;

    assign wordIdx = memReq.word[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            memAck <= 1'b0;
            latCount <= '0;
            for (int w = 0; w < memWords; w++) begin
                mem[w] <= '0;
            end
        end else begin
            if (memAck && !memReqValid) begin
                memAck <= 1'b0;
            end
            if (memReqValid && !busy && !memAck) begin
                busy <= 1'b1;
                latCount <= CNT_W'(memLatency - 1);   // ack lands memLatency edges later.
            end else if (busy) begin
                if (latCount == '0) begin
                    busy <= 1'b0;
                    memAck <= 1'b1;
                    if (memReq.write) begin
                        mem[wordIdx] <= mergeLanes(mem[wordIdx], memReq.data, memReq.byteEn);
                    end else begin
                        memRdata <= mem[wordIdx];
                    end
                end else begin
                    latCount <= latCount - 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        memReqValid |-> memReq.word < memWords)
        else $error("memory word index out of range");

    // requester must hold the request until the ack.
    assert property (@(posedge clk) disable iff (reset)
        $fell(memReqValid) |-> memAck)
        else $error("memReqValid dropped before memAck rose");

endmodule

//--- logic/memStage.sv
`timescale 1ns/100ps

module memStage #(
    parameter int numEntries = 4,
    parameter int memWords = 256,
    parameter int memLatency = 3
) (
    input  logic                           clk,
    input  logic                           reset,
    input  memStagePkg::cpuReq_t           cpuReq,
    input  logic                           cpuReqValid,
    output logic                           cpuAck,
    output logic [memStagePkg::DATA_W-1:0] loadData,
    output logic                           bufferEmpty
);
    import memStagePkg::*;

    memReq_t memReq;
    logic memReqValid;
    logic memAck;
    logic [DATA_W-1:0] memRdata;

    storeBuffer #(
        .numEntries(numEntries)
    ) i_storeBuffer (
        .clk(clk),
        .reset(reset),
        .cpuReq(cpuReq),
        .cpuReqValid(cpuReqValid),
        .cpuAck(cpuAck),
        .loadData(loadData),
        .memReq(memReq),
        .memReqValid(memReqValid),
        .memAck(memAck),
        .memRdata(memRdata),
        .bufferEmpty(bufferEmpty)
    );

    dataMemory #(
        .memWords(memWords),
        .memLatency(memLatency)
    ) i_dataMemory (
        .clk(clk),
        .reset(reset),
        .memReq(memReq),
        .memReqValid(memReqValid),
        .memAck(memAck),
        .memRdata(memRdata)
    );

endmodule

//--- logic/memStagePkg.sv
package memStagePkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int LANES = 4;
    localparam int BYTE_W = DATA_W / LANES;
    localparam int LANE_W = $clog2(LANES);
    localparam int WORD_W = ADDR_W - LANE_W;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } accessOp_e;

    typedef enum logic {
        SIZE_BYTE = 1'b0,
        SIZE_WORD = 1'b1
    } accessSize_e;

    // byte address, or word index plus byte lane.
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [WORD_W-1:0] word;
            logic [LANE_W-1:0] lane;
        } split;
    } memAddr_u;

    typedef struct packed {
        accessOp_e         op;
        accessSize_e       size;
        memAddr_u          addr;
        logic [DATA_W-1:0] data;   // byte stores use the low byte.
    } cpuReq_t;

    typedef struct packed {
        logic              write;
        logic [WORD_W-1:0] word;
        logic [LANES-1:0]  byteEn;
        logic [DATA_W-1:0] data;
    } memReq_t;

    function automatic logic [DATA_W-1:0] mergeLanes(
        input logic [DATA_W-1:0] oldWord,
        input logic [DATA_W-1:0] newWord,
        input logic [LANES-1:0]  mask
    );
        logic [DATA_W-1:0] result;
        result = oldWord;
        for (int l = 0; l < LANES; l++) begin
            if (mask[l]) begin
                result[l*BYTE_W +: BYTE_W] = newWord[l*BYTE_W +: BYTE_W];
            end
        end
        return result;
    endfunction

endpackage

//--- logic/storeBuffer.sv
`timescale 1ns/100ps

module storeBuffer #(
    parameter int numEntries = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  memStagePkg::cpuReq_t           cpuReq,
    input  logic                           cpuReqValid,
    output logic                           cpuAck,
    output logic [memStagePkg::DATA_W-1:0] loadData,
    output memStagePkg::memReq_t           memReq,
    output logic                           memReqValid,
    input  logic                           memAck,
    input  logic [memStagePkg::DATA_W-1:0] memRdata,
    output logic                           bufferEmpty
);
    import memStagePkg::*;

    localparam int IDX_W = (numEntries > 1) ? $clog2(numEntries) : 1;
    localparam int CNT_W = $clog2(numEntries + 1);
    localparam int SUM_W = CNT_W + 1;
    localparam logic [1:0] MEM_IDLE = 2'd0;
    localparam logic [1:0] MEM_REQ = 2'd1;
    localparam logic [1:0] MEM_RELEASE = 2'd2;

    logic [WORD_W-1:0] entryWord [numEntries];
    logic [DATA_W-1:0] entryData [numEntries];
    logic [LANES-1:0] entryMask [numEntries];
    logic [numEntries-1:0] entryValid;
    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [SUM_W-1:0] tailSum;
    logic [CNT_W-1:0] count;
    logic [1:0] memState;

    logic [WORD_W-1:0] reqWord;
    logic [LANE_W-1:0] reqLane;
    logic [LANES-1:0] needMask;
    logic [DATA_W-1:0] storeData;
    logic newReq;
    logic isStore;
    logic hit;
    logic [IDX_W-1:0] hitIdx;
    logic hitAtHead;
    logic covered;
    logic draining;
    logic storeAccept;
    logic storeAlloc;
    logic loadForward;
    logic readStart;
    logic drainStart;
    logic drainDone;
    logic readDone;
    logic dupFound;

    function automatic logic [IDX_W-1:0] nextIdx(input logic [IDX_W-1:0] idx);
        return (idx == IDX_W'(numEntries - 1)) ? '0 : idx + 1'b1;
    endfunction

    function automatic logic [DATA_W-1:0] extractLoad(
        input logic [DATA_W-1:0] src,
        input accessSize_e       size,
        input logic [LANE_W-1:0] lane
    );
        if (size == SIZE_WORD) begin
            return src;
        end
        return DATA_W'(src[lane*BYTE_W +: BYTE_W]);   // zero-extended.
    endfunction

    assign reqWord = cpuReq.addr.split.word;
    assign reqLane = cpuReq.addr.split.lane;
    assign needMask = (cpuReq.size == SIZE_WORD) ? {LANES{1'b1}} : LANES'(1) << reqLane;
    assign storeData = (cpuReq.size == SIZE_WORD) ? cpuReq.data
                                                  : {LANES{cpuReq.data[BYTE_W-1:0]}};

    assign tailSum = SUM_W'(head) + SUM_W'(count);
    assign tail = (tailSum >= SUM_W'(numEntries)) ? IDX_W'(tailSum - SUM_W'(numEntries))
                                                  : IDX_W'(tailSum);

    always_comb begin
        hit = 1'b0;
        hitIdx = '0;
        for (int i = 0; i < numEntries; i++) begin
            if (entryValid[i] && entryWord[i] == reqWord) begin
                hit = 1'b1;
                hitIdx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        dupFound = 1'b0;
        for (int i = 0; i < numEntries; i++) begin
            for (int j = i + 1; j < numEntries; j++) begin
                if (entryValid[i] && entryValid[j] && entryWord[i] == entryWord[j]) begin
                    dupFound = 1'b1;
                end
            end
        end
    end

    assign newReq = cpuReqValid && !cpuAck;
    assign isStore = (cpuReq.op == OP_STORE);
    assign hitAtHead = hit && (hitIdx == head);
    assign covered = hit && ((entryMask[hitIdx] & needMask) == needMask);
    assign draining = (memState == MEM_REQ) && memReq.write;   // head entry is frozen.

    assign storeAccept = newReq && isStore && !(draining && hitAtHead)
                         && (hit || count != CNT_W'(numEntries));
    assign storeAlloc = storeAccept && !hit;
    assign loadForward = newReq && !isStore && covered;
    assign readStart = newReq && !isStore && !hit && (memState == MEM_IDLE);
    // a merge into the head entry goes first, the drain waits a cycle.
    assign drainStart = (memState == MEM_IDLE) && !readStart && (count != '0)
                        && !(storeAccept && hitAtHead);
    assign drainDone = draining && memAck;
    assign readDone = (memState == MEM_REQ) && !memReq.write && memAck;

    assign bufferEmpty = (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
            head <= '0;
            count <= '0;
            memState <= MEM_IDLE;
            memReqValid <= 1'b0;
            cpuAck <= 1'b0;
        end else begin
            if (cpuAck && !cpuReqValid) begin
                cpuAck <= 1'b0;
            end
            if (storeAccept || loadForward || readDone) begin
                cpuAck <= 1'b1;
            end
            if (storeAlloc) begin
                entryValid[tail] <= 1'b1;
            end
            if (drainDone) begin
                entryValid[head] <= 1'b0;
                head <= nextIdx(head);
            end
            count <= count + CNT_W'(storeAlloc) - CNT_W'(drainDone);
            case (memState)
                MEM_IDLE: begin
                    if (readStart || drainStart) begin
                        memReqValid <= 1'b1;
                        memState <= MEM_REQ;
                    end
                end
                MEM_REQ: begin
                    if (memAck) begin
                        memReqValid <= 1'b0;
                        memState <= MEM_RELEASE;
                    end
                end
                MEM_RELEASE: begin
                    if (!memAck) begin
                        memState <= MEM_IDLE;   // four-phase cycle closed.
                    end
                end
                default: memState <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (storeAlloc) begin
            entryWord[tail] <= reqWord;
            entryData[tail] <= storeData;
            entryMask[tail] <= needMask;
        end else if (storeAccept) begin
            entryData[hitIdx] <= mergeLanes(entryData[hitIdx], storeData, needMask);
            entryMask[hitIdx] <= entryMask[hitIdx] | needMask;
        end
        if (loadForward) begin
            loadData <= extractLoad(entryData[hitIdx], cpuReq.size, reqLane);
        end else if (readDone) begin
            loadData <= extractLoad(memRdata, cpuReq.size, reqLane);
        end
        if (readStart) begin
            memReq <= '{write: 1'b0, word: reqWord, byteEn: needMask, data: '0};
        end else if (drainStart) begin
            memReq <= '{write: 1'b1, word: entryWord[head], byteEn: entryMask[head],
                        data: entryData[head]};
        end
    end

    assert property (@(posedge clk) disable iff (reset) count <= CNT_W'(numEntries))
        else $error("store buffer count exceeds numEntries");

    assert property (@(posedge clk) disable iff (reset) !dupFound)
        else $error("two valid store buffer entries hold the same word");

    assert property (@(posedge clk) disable iff (reset)
        memReqValid && $past(memReqValid) |-> $stable(memReq))
        else $error("memReq changed while memReqValid was high");

endmodule

//--- run.sh
#!/bin/sh
# Build and run memStageTb with Verilator, then scan the log for the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module memStageTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/VmemStageTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "simulation log holds no result line"
    exit 1
fi
exit 0

//--- verif/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;   // released just after the edge, like other inputs.
    end
endmodule

//--- verif/memStageTb.sv
`timescale 1ns/100ps

module memStageTb;
    import memStagePkg::*;

    localparam int MEM_WORDS = 256;
    localparam int ACK_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 400;

    logic clk;
    logic reset;
    cpuReq_t cpuReq;
    logic cpuReqValid;
    logic cpuAck;
    logic [DATA_W-1:0] loadData;
    logic bufferEmpty;

    logic [7:0] model [MEM_WORDS*LANES];   // byte-level image of the memory.
    logic [DATA_W-1:0] expLoad;
    logic emptyCheck;
    int errorCount;
    int errorsAtStart;
    int testCount;
    int waitCycles;
    accessOp_e rOp;
    accessSize_e rSize;
    logic [ADDR_W-1:0] rAddr;

    clockGen i_clockGen (
        .clk(clk),
        .reset(reset)
    );

    memStage #(
        .numEntries(4),
        .memWords(MEM_WORDS),
        .memLatency(3)
    ) i_memStage (
        .clk(clk),
        .reset(reset),
        .cpuReq(cpuReq),
        .cpuReqValid(cpuReqValid),
        .cpuAck(cpuAck),
        .loadData(loadData),
        .bufferEmpty(bufferEmpty)
    );

    function automatic logic [DATA_W-1:0] expectedLoad(
        input accessSize_e       size,
        input logic [ADDR_W-1:0] addr
    );
        logic [DATA_W-1:0] result;
        logic [ADDR_W-1:0] base;
        base = {addr[ADDR_W-1:2], 2'b00};
        result = '0;
        if (size == SIZE_WORD) begin
            for (int l = 0; l < LANES; l++) begin
                result[l*8 +: 8] = model[base + l];
            end
        end else begin
            result[7:0] = model[addr];   // zero-extended.
        end
        return result;
    endfunction

    task automatic applyStore(
        input accessSize_e       size,
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] data
    );
        logic [ADDR_W-1:0] base;
        base = {addr[ADDR_W-1:2], 2'b00};
        if (size == SIZE_WORD) begin
            for (int l = 0; l < LANES; l++) begin
                model[base + l] = data[l*8 +: 8];
            end
        end else begin
            model[addr] = data[7:0];
        end
    endtask

    // one four-phase transaction on the processor port.
    task automatic doAccess(
        input accessOp_e         op,
        input accessSize_e       size,
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] data
    );
        int cycles;
        cpuReq.op = op;
        cpuReq.size = size;
        cpuReq.addr.raw = addr;
        cpuReq.data = data;
        if (op == OP_LOAD) begin
            expLoad = expectedLoad(size, addr);
        end
        cpuReqValid = 1'b1;
        cycles = 0;
        while (!cpuAck && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!cpuAck) begin
            $display("%0t: request to address %h was never acknowledged", $time, addr);
            errorCount++;
        end else if (op == OP_STORE) begin
            applyStore(size, addr, data);
        end
        cpuReqValid = 1'b0;
        cycles = 0;
        while (cpuAck && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cpuAck) begin
            $display("%0t: cpuAck stayed high after the request was dropped", $time);
            errorCount++;
        end
    endtask

    task automatic waitDrained();
        int cycles;
        cycles = 0;
        while (!bufferEmpty && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!bufferEmpty) begin
            $display("%0t: store buffer did not drain in time", $time);
        end
        emptyCheck = 1'b1;
        @(posedge clk);
        #1;
        emptyCheck = 1'b0;
    endtask

    task automatic reportTest(input string name);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsAtStart);
        errorsAtStart = errorCount;
    endtask

    assert property (@(posedge clk) disable iff (reset)
        $rose(cpuAck) && cpuReq.op == OP_LOAD |-> loadData == expLoad)
        else begin
            $display("[ERROR] %0t: load of %h returned %h, expected %h",
                     $time, cpuReq.addr.raw, loadData, expLoad);
            errorCount++;
        end

    assert property (@(posedge clk) disable iff (reset)
        cpuAck |-> cpuReqValid || $past(cpuReqValid))
        else begin
            $display("[ERROR] %0t: cpuAck high without a request", $time);
            errorCount++;
        end

    assert property (@(posedge clk) disable iff (reset) emptyCheck |-> bufferEmpty)
        else begin
            $display("[ERROR] %0t: bufferEmpty low after the drain wait", $time);
            errorCount++;
        end

    initial begin
        void'($urandom(51));
        cpuReq = '0;
        cpuReqValid = 1'b0;
        expLoad = '0;
        emptyCheck = 1'b0;
        errorCount = 0;
        errorsAtStart = 0;
        testCount = 0;
        for (int b = 0; b < MEM_WORDS * LANES; b++) begin
            model[b] = 8'h00;
        end
        waitCycles = 0;
        while (reset !== 1'b0 && waitCycles < 20) begin
            @(posedge clk);
            waitCycles++;
        end
        if (reset !== 1'b0) begin
            $display("%0t: reset was never released", $time);
            $display("TEST FAILED");
            $finish;
        end
        #1;

        waitDrained();
        doAccess(OP_LOAD, SIZE_WORD, 32'h0, '0);
        doAccess(OP_LOAD, SIZE_WORD, 32'h40, '0);
        doAccess(OP_LOAD, SIZE_WORD, 32'h3fc, '0);
        doAccess(OP_LOAD, SIZE_BYTE, 32'h105, '0);
        reportTest("reset state");

        doAccess(OP_STORE, SIZE_WORD, 32'h10, 32'hdeadbeef);
        doAccess(OP_LOAD, SIZE_WORD, 32'h10, '0);
        reportTest("store then forwarded load");

        doAccess(OP_STORE, SIZE_WORD, 32'h20, 32'h11223344);
        doAccess(OP_STORE, SIZE_BYTE, 32'h21, 32'h000000aa);
        doAccess(OP_STORE, SIZE_BYTE, 32'h23, 32'h00000055);
        doAccess(OP_LOAD, SIZE_WORD, 32'h20, '0);
        for (int l = 0; l < LANES; l++) begin
            doAccess(OP_LOAD, SIZE_BYTE, 32'h20 + l, '0);
        end
        reportTest("byte merge");

        waitDrained();
        for (int w = 0; w < 6; w++) begin
            doAccess(OP_STORE, SIZE_WORD, 32'h100 + w * 4, 32'hc0de0000 + w);
        end
        waitDrained();
        for (int w = 0; w < 6; w++) begin
            doAccess(OP_LOAD, SIZE_WORD, 32'h100 + w * 4, '0);
        end
        reportTest("full buffer stall");

        doAccess(OP_STORE, SIZE_WORD, 32'h80, 32'h01020304);
        waitDrained();
        doAccess(OP_STORE, SIZE_BYTE, 32'h82, 32'h000000ff);
        doAccess(OP_LOAD, SIZE_WORD, 32'h80, '0);   // partial hit, waits for drain.
        reportTest("partial load waits for drain");

        for (int n = 0; n < 300; n++) begin
            rOp = accessOp_e'($urandom_range(0, 1));
            rSize = accessSize_e'($urandom_range(0, 1));
            rAddr = ADDR_W'($urandom_range(0, 15) * 4);
            if (rSize == SIZE_BYTE) begin
                rAddr[1:0] = 2'($urandom_range(0, 3));
            end
            doAccess(rOp, rSize, rAddr, $urandom());
        end
        waitDrained();
        reportTest("random traffic");

        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/memStagePkg.sv
logic/storeBuffer.sv
logic/dataMemory.sv
logic/memStage.sv
verif/clockGen.sv
verif/memStageTb.sv
